//--- filelist.f
sevenseg_pkg.sv
key_debounce.sv
count_source.sv
bcd_convert.sv
digit_frame.sv
serial_shift.sv
sevenseg_top.sv
sevenseg_props.sv
sevenseg_tb.sv

//--- Makefile
# Verilator build and run for the seven-segment serial driver testbench

VERILATOR ?= verilator
TOP       ?= sevenseg_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sevenseg_tb.sv
// directed testbench for the serial seven-segment driver, decodes the bus and checks each frame
`timescale 1ns/1ns

module sevenseg_tb;

	import sevenseg_pkg::*;

	localparam int tick_div     = 3000;
	localparam int stable_ticks = 4;
	localparam int serial_div   = 2;
	localparam int intensity    = 5;
	localparam int clk_period   = 8;

	// accept, 16 bits of two half periods, tail, latch
	localparam int word_cycles     = 2 * serial_div * word_bits + serial_div + 2;
	// eight digit words plus one double-dabble pass
	localparam int frame_cycles    = num_digits * word_cycles + count_bits + 8;
	// ticks before the freeze push the count past nine
	localparam int warmup_ticks    = 11;
	localparam int warmup_frames   = (warmup_ticks + 1) * tick_div / frame_cycles + 1;
	// init 2, order 3, freeze 6, hex and decimal 10, run 14, with spare
	localparam int expected_frames = 40 + warmup_frames;
	localparam int watchdog_ns     = 2 * expected_frames * frame_cycles * clk_period;

	logic    slow_clk;
	logic    rst;
	logic    key_freeze;
	logic    key_hex;
	logic    seg_dat;
	logic    seg_sel;
	logic    seg_clk;
	status_t led;

	// decoded words in arrival order
	logic [15:0] rx_q[$];
	// next word to hand out
	int          rd_idx;
	logic [15:0] rx_shift;
	int          rx_bits;
	logic        clk_q;
	logic        sel_q;
	// a word was latched on the previous edge
	logic        latched_q;

	sevenseg_top #(
		.tick_div     (tick_div),
		.stable_ticks (stable_ticks),
		.serial_div   (serial_div),
		.intensity    (intensity)
	) i_sevenseg_top (
		.slow_clk, .rst, .key_freeze, .key_hex,
		.seg_dat, .seg_sel, .seg_clk, .led
	);

	bind serial_shift sevenseg_props i_sevenseg_props (
		.slow_clk, .rst, .word_valid, .word_ready, .seg_clk, .seg_sel
	);

	initial slow_clk = 1'b0;
	always #(clk_period / 2) slow_clk = !slow_clk;

	// ----------------------------------------
	// serial frame decoder
	// ----------------------------------------
	// bus outputs are registered, so edges show up one slow_clk later
	always @(posedge slow_clk) begin
		if (rst) begin
			rx_bits   <= 0;
			clk_q     <= 1'b0;
			sel_q     <= 1'b1;
			latched_q <= 1'b0;
		end else begin
			clk_q <= seg_clk;
			sel_q <= seg_sel;
			// shifter stays busy for the whole select window
			if (!seg_sel)
				check("serial decoder led.busy in word", 64'd1, 64'(led.busy));
			// ready again one cycle after the latch
			if (latched_q)
				check("serial decoder led.busy after latch", 64'd0, 64'(led.busy));
			latched_q <= seg_sel && !sel_q;
			// data is stable across the rising clock
			if (seg_clk && !clk_q) begin
				rx_shift <= {rx_shift[14:0], seg_dat};
				rx_bits  <= rx_bits + 1;
			end
			if (!seg_sel && sel_q)
				rx_bits <= 0;
			// rising select latches one word
			if (seg_sel && !sel_q) begin
				if (rx_bits != word_bits)
					abort_run($sformatf("serial word latched after %0d bits", rx_bits));
				rx_q.push_back(rx_shift);
			end
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	// segments a..g on bits 6..0, built from the lit segment letters
	function automatic logic [7:0] glyph(input logic [3:0] nib);
		string lit;
		logic [7:0] p;
		case (nib)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'ha: lit = "abcefg";
			4'hb: lit = "cdefg";
			4'hc: lit = "adef";
			4'hd: lit = "bcdeg";
			4'he: lit = "adefg";
			default: lit = "aefg";
		endcase
		p = 8'h00;
		for (int i = 0; i < lit.len(); i++)
			p = p | (8'h40 >> (lit[i] - 8'h61));
		return p;
	endfunction

	// -1 for a byte that is no digit shape
	function automatic int glyph_index(input logic [7:0] p);
		for (int n = 0; n < 16; n++)
			if (glyph(4'(n)) == p)
				return n;
		return -1;
	endfunction

	function automatic logic [63:0] decimal_frame(input int value);
		logic [63:0] f;
		int rest;
		rest = value;
		for (int k = 0; k < num_digits; k++) begin
			f[8*k +: 8] = glyph(4'(rest % 10));
			rest = rest / 10;
		end
		return f;
	endfunction

	// decode, init register, scan limit, shutdown, test
	function automatic logic [15:0] init_word(input int i);
		case (i)
			0: return 16'h0900;
			1: return {8'h0a, 8'(intensity)};
			2: return 16'h0b07;
			3: return 16'h0c01;
			default: return 16'h0f00;
		endcase
	endfunction

	task automatic get_word(output logic [15:0] w);
		int waited;
		waited = 0;
		while (rd_idx >= rx_q.size()) begin
			@(negedge slow_clk);
			waited++;
			if (waited > 2 * frame_cycles)
				abort_run("no serial word arrived within two frame times");
		end
		w = rx_q[rd_idx];
		rd_idx++;
	endtask

	// one frame of eight digit words, digit 1 in the low byte
	task automatic read_frame(input string name, input bit resync, output logic [63:0] frame);
		logic [15:0] w;
		int skipped;
		skipped = 0;
		if (resync)
			rd_idx = rx_q.size();
		get_word(w);
		// after a resync drop words until a frame starts
		while (resync && w[15:8] != 8'd1) begin
			skipped++;
			if (skipped > 2 * num_digits)
				abort_run($sformatf("%s: no frame start found on the serial bus", name));
			get_word(w);
		end
		check({name, " address"}, 64'd1, 64'(w[15:8]));
		frame[7:0] = w[7:0];
		for (int k = 2; k <= num_digits; k++) begin
			get_word(w);
			check({name, " address"}, 64'(k), 64'(w[15:8]));
			frame[8*(k-1) +: 8] = w[7:0];
		end
	endtask

	task automatic frame_value(input string name, input logic [63:0] frame, input int radix,
		output int value);
		int d;
		value = 0;
		for (int k = num_digits - 1; k >= 0; k--) begin
			d = glyph_index(frame[8*k +: 8]);
			if (d < 0 || d >= radix)
				abort_run($sformatf("%s: digit %0d shows 0x%0h, not a valid digit",
					name, k + 1, frame[8*k +: 8]));
			value = value * radix + d;
		end
	endtask

	task automatic press_key(input bit hex);
		int hold;
		hold = stable_ticks + 6 + int'($urandom % 8);
		@(negedge slow_clk);
		if (hex)
			key_hex = 1'b1;
		else
			key_freeze = 1'b1;
		repeat (hold) @(negedge slow_clk);
		key_hex    = 1'b0;
		key_freeze = 1'b0;
		// let the release settle before the next press
		repeat (stable_ticks + 6 + int'($urandom % 8)) @(negedge slow_clk);
	endtask

	task automatic wait_flag(input string what, input bit on_freeze, input logic want);
		int waited;
		waited = 0;
		while ((on_freeze ? led.frozen : led.hex_mode) !== want) begin
			@(negedge slow_clk);
			waited++;
			if (waited > 16 * stable_ticks + 64)
				abort_run($sformatf("%s did not reach %0b after the key press", what, want));
		end
	endtask

	// counts n tick periods on led.tick, each one tick_div cycles long
	task automatic wait_ticks(input string name, input int n);
		int gap;
		gap = 0;
		// line up on a tick first
		while (!led.tick) begin
			@(negedge slow_clk);
			gap++;
			if (gap > tick_div)
				abort_run($sformatf("%s: no tick within %0d cycles", name, tick_div));
		end
		for (int t = 0; t < n; t++) begin
			gap = 1;
			@(negedge slow_clk);
			while (!led.tick && gap <= tick_div) begin
				@(negedge slow_clk);
				gap++;
			end
			check({name, " tick period"}, 64'(tick_div), 64'(gap));
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_init();
		logic [15:0] w;
		for (int i = 0; i < 5; i++) begin
			get_word(w);
			check($sformatf("test_init word %0d", i), 64'(init_word(i)), 64'(w));
		end
	endtask

	task automatic test_frame_order();
		logic [63:0] frame;
		int v;
		for (int f = 0; f < 3; f++) begin
			read_frame($sformatf("test_frame_order frame %0d", f), 1'b0, frame);
			frame_value("test_frame_order", frame, 16, v);
		end
	endtask

	task automatic test_freeze();
		logic [63:0] first;
		logic [63:0] second;
		wait_ticks("test_freeze", warmup_ticks);
		press_key(1'b0);
		wait_flag("led.frozen", 1'b1, 1'b1);
		// up to two items predate the freeze, skip their frames
		read_frame("test_freeze", 1'b1, first);
		read_frame("test_freeze", 1'b0, first);
		read_frame("test_freeze", 1'b0, first);
		read_frame("test_freeze", 1'b0, second);
		check("test_freeze frames", first, second);
	endtask

	task automatic test_hex_decimal();
		logic [63:0] frame;
		int v;
		press_key(1'b1);
		wait_flag("led.hex_mode", 1'b0, 1'b1);
		// up to two items still carry the old mode
		read_frame("test_hex_decimal hex", 1'b1, frame);
		read_frame("test_hex_decimal hex", 1'b0, frame);
		read_frame("test_hex_decimal hex", 1'b0, frame);
		// digits 6 and 7 carry zero in hex
		check("test_hex_decimal top digits", 64'({glyph(4'h0), glyph(4'h0)}), 64'(frame[63:48]));
		frame_value("test_hex_decimal hex", frame, 16, v);
		press_key(1'b1);
		wait_flag("led.hex_mode", 1'b0, 1'b0);
		read_frame("test_hex_decimal decimal", 1'b1, frame);
		read_frame("test_hex_decimal decimal", 1'b0, frame);
		read_frame("test_hex_decimal decimal", 1'b0, frame);
		check("test_hex_decimal decimal", decimal_frame(v), frame);
	endtask

	task automatic test_run();
		logic [63:0] frame;
		int prev;
		int v;
		bit advanced;
		press_key(1'b0);
		wait_flag("led.frozen", 1'b1, 1'b0);
		read_frame("test_run", 1'b1, frame);
		frame_value("test_run", frame, 10, prev);
		advanced = 1'b0;
		// twelve frames span more than two ticks
		for (int f = 0; f < 12; f++) begin
			read_frame("test_run", 1'b0, frame);
			frame_value("test_run", frame, 10, v);
			if (v < prev)
				abort_run($sformatf("test_run: count went down from %0d to %0d", prev, v));
			if (v > prev)
				advanced = 1'b1;
			prev = v;
		end
		check("test_run advanced", 64'd1, 64'(advanced));
	endtask

	// ----------------------------------------
	// sequence and watchdog
	// ----------------------------------------
	initial begin
		void'($urandom(71392));
		rd_idx     = 0;
		rst        = 1'b1;
		key_freeze = 1'b0;
		key_hex    = 1'b0;
		repeat (3) @(posedge slow_clk);
		@(negedge slow_clk);
		rst = 1'b0;
		test_init();
		test_frame_order();
		test_freeze();
		test_hex_decimal();
		test_run();
		$display("All tests passed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		abort_run($sformatf("watchdog expired after %0d ns", watchdog_ns));
	end

endmodule

//--- sevenseg_props.sv
// serial bus properties for serial_shift, attached by bind from the testbench
`timescale 1ns/1ns

module sevenseg_props (
	input logic slow_clk,
	input logic rst,
	input logic word_valid,
	input logic word_ready,
	input logic seg_clk,
	input logic seg_sel
);

	// ----------------------------------------
	// bus shape
	// ----------------------------------------
	// clock idles low outside a word
	property clk_idle_low;
		@(posedge slow_clk) disable iff (rst) seg_sel |-> !seg_clk;
	endproperty

	// shifter cannot take a word mid transfer
	property busy_while_selected;
		@(posedge slow_clk) disable iff (rst) !seg_sel |-> !word_ready;
	endproperty

	// no word offered, select stays up
	property sel_holds_without_word;
		@(posedge slow_clk) disable iff (rst) (seg_sel && !word_valid) |=> seg_sel;
	endproperty

	a_clk_idle_low: assert property (clk_idle_low)
		else $error("seg_clk is high while seg_sel is high");
	a_busy_while_selected: assert property (busy_while_selected)
		else $error("word_ready is high while seg_sel is low");
	a_sel_holds: assert property (sel_holds_without_word)
		else $error("seg_sel fell without a valid word");

endmodule

//--- sevenseg_top.sv
// top level: counter source, bcd conversion, framing and serial output, plus status leds
`timescale 1ns/1ns

module sevenseg_top #(
	parameter int tick_div     = 3000,
	parameter int stable_ticks = 4,
	parameter int serial_div   = 2,
	parameter int intensity    = 5
) (
	input  logic                  slow_clk,
	input  logic                  rst,
	input  logic                  key_freeze,
	input  logic                  key_hex,
	output logic                  seg_dat,
	output logic                  seg_sel,
	output logic                  seg_clk,
	output sevenseg_pkg::status_t led
);

	import sevenseg_pkg::*;

	count_t  sample;
	logic    sample_valid;
	logic    sample_ready;
	digits_t digits;
	logic    digits_valid;
	logic    digits_ready;
	word_t   word;
	logic    word_valid;
	logic    word_ready;
	logic    busy;
	logic    tick;

	// ----------------------------------------
	// input side
	// ----------------------------------------
	count_source #(.tick_div(tick_div), .stable_ticks(stable_ticks)) i_count_source (
		.slow_clk, .rst, .key_freeze, .key_hex,
		.sample, .sample_valid, .sample_ready, .tick
	);

	// ----------------------------------------
	// processing
	// ----------------------------------------
	bcd_convert i_bcd_convert (
		.slow_clk, .rst,
		.sample, .sample_valid, .sample_ready,
		.digits, .digits_valid, .digits_ready
	);

	// ----------------------------------------
	// output side
	// ----------------------------------------
	digit_frame #(.intensity(intensity)) i_digit_frame (
		.slow_clk, .rst,
		.digits, .digits_valid, .digits_ready,
		.word, .word_valid, .word_ready
	);

	serial_shift #(.serial_div(serial_div)) i_serial_shift (
		.slow_clk, .rst,
		.word, .word_valid, .word_ready, .busy,
		.seg_dat, .seg_clk, .seg_sel
	);

	// flags come from the live sample, not from the frame on the bus
	assign led = '{busy: busy, frozen: sample.frozen, hex_mode: sample.hex_mode, tick: tick};

endmodule

//--- serial_shift.sv
// output side: shifts one 16-bit word MSB first on seg_dat / seg_clk, framed by seg_sel
`timescale 1ns/1ns

module serial_shift #(
	parameter int serial_div = 2
) (
	input  logic                slow_clk,
	input  logic                rst,
	input  sevenseg_pkg::word_t word,
	input  logic                word_valid,
	output logic                word_ready,
	output logic                busy,
	output logic                seg_dat,
	output logic                seg_clk,
	output logic                seg_sel
);

	import sevenseg_pkg::*;

	localparam int div_bits = (serial_div > 1) ? $clog2(serial_div) : 1;
	localparam int bit_bits = $clog2(word_bits);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_tail,
		st_latch
	} state_t;

	state_t state;
	logic [word_bits-1:0] shreg;
	logic [bit_bits-1:0]  bit_cnt;
	logic [div_bits-1:0]  div_cnt;
	// end of a half period
	logic half_done;

	assign word_ready = (state == st_idle);
	assign busy       = !word_ready;
	assign half_done  = (div_cnt == div_bits'(serial_div - 1));

	// ----------------------------------------
	// bus waveform
	// ----------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			state   <= st_idle;
			shreg   <= '0;
			bit_cnt <= '0;
			div_cnt <= '0;
			seg_dat <= 1'b0;
			seg_clk <= 1'b0;
			seg_sel <= 1'b1;
		end else begin
			div_cnt <= half_done ? '0 : div_cnt + 1'b1;
			case (state)
				st_idle: begin
					div_cnt <= '0;
					if (word_valid) begin
						// select low and msb on the line together
						shreg   <= word;
						seg_dat <= word[word_bits-1];
						seg_sel <= 1'b0;
						bit_cnt <= '0;
						state   <= st_shift;
					end
				end
				st_shift: begin
					if (half_done) begin
						seg_clk <= !seg_clk;
						// falling edge, next bit or done
						if (seg_clk) begin
							if (bit_cnt == bit_bits'(word_bits - 1)) begin
								seg_dat <= 1'b0;
								state   <= st_tail;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								shreg   <= shreg << 1;
								seg_dat <= shreg[word_bits-2];
							end
						end
					end
				end
				st_tail: begin
					// rising select latches the word
					if (half_done) begin
						seg_sel <= 1'b1;
						state   <= st_latch;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- digit_frame.sv
// output side: frames one digits item as init words (first frame only) and eight digit words
`timescale 1ns/1ns

module digit_frame #(
	parameter int intensity = 5
) (
	input  logic                  slow_clk,
	input  logic                  rst,
	input  sevenseg_pkg::digits_t digits,
	input  logic                  digits_valid,
	output logic                  digits_ready,
	output sevenseg_pkg::word_t   word,
	output logic                  word_valid,
	input  logic                  word_ready
);

	import sevenseg_pkg::*;

	// words 0..4 are init, 5..12 are the digits
	localparam int num_init = 5;
	localparam int last_idx = num_init + num_digits - 1;
	localparam int sel_bits = $clog2(num_digits);

	logic active;
	// init sequence goes out once after reset
	logic init_done;
	logic [3:0] idx;
	logic [sel_bits-1:0] dsel;
	logic [3:0] nib;
	// captured item, payload only
	digits_t held;

	assign digits_ready = !active;
	assign word_valid   = active;

	// ----------------------------------------
	// word selection
	// ----------------------------------------
	always_comb begin
		dsel = sel_bits'(idx - 4'(num_init));
		nib  = held.digit[dsel];
		case (idx)
			4'd0: word = '{addr: reg_decode, data: 8'h00};
			4'd1: word = '{addr: reg_intensity, data: 8'(intensity)};
			// scan all eight digits
			4'd2: word = '{addr: reg_scan_limit, data: 8'h07};
			// leave shutdown
			4'd3: word = '{addr: reg_shutdown, data: 8'h01};
			4'd4: word = '{addr: reg_test, data: 8'h00};
			// digit k at address k
			default: word = '{addr: 8'(idx - 4'(num_init - 1)), data: seg_pattern(nib)};
		endcase
	end

	// ----------------------------------------
	// sequencer
	// ----------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			active    <= 1'b0;
			init_done <= 1'b0;
			idx       <= '0;
		end else if (!active) begin
			if (digits_valid) begin
				active <= 1'b1;
				// skip the init words once they have gone out
				idx    <= init_done ? 4'(num_init) : 4'd0;
			end
		end else if (word_ready) begin
			if (idx == 4'(num_init - 1))
				init_done <= 1'b1;
			if (idx == 4'(last_idx))
				active <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge slow_clk) begin
		if (digits_valid && digits_ready)
			held <= digits;
	end

	// words wait here while the shifter is busy
	// reg_noop is not sent, the display needs no padding
	// frame length is num_init + num_digits on the first pass

endmodule

//--- bcd_convert.sv
// processing part: sequential double-dabble for decimal samples, nibble pass-through for hex
`timescale 1ns/1ns

module bcd_convert (
	input  logic                  slow_clk,
	input  logic                  rst,
	input  sevenseg_pkg::count_t  sample,
	input  logic                  sample_valid,
	output logic                  sample_ready,
	output sevenseg_pkg::digits_t digits,
	output logic                  digits_valid,
	input  logic                  digits_ready
);

	import sevenseg_pkg::*;

	localparam int step_bits = $clog2(count_bits);
	localparam int bcd_bits  = 4 * num_digits;

	logic converting;
	logic accept;
	logic last_step;
	logic [step_bits-1:0]  step;
	logic [count_bits-1:0] bin_q;
	logic [bcd_bits-1:0]   bcd_q;
	// bcd after the add-3 correction
	logic [bcd_bits-1:0]   bcd_adj;

	// one item in flight
	assign sample_ready = !converting && !digits_valid;
	assign accept       = sample_valid && sample_ready;
	assign last_step    = converting && (step == step_bits'(count_bits - 1));

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int i = 0; i < num_digits; i++) begin
			if (bcd_q[4*i +: 4] >= 4'd5)
				bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
		end
	end

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			converting   <= 1'b0;
			digits_valid <= 1'b0;
			step         <= '0;
		end else if (accept) begin
			// hex goes straight out, decimal takes count_bits steps
			converting   <= !sample.hex_mode;
			digits_valid <= sample.hex_mode;
			step         <= '0;
		end else if (converting) begin
			step <= step + 1'b1;
			if (last_step) begin
				converting   <= 1'b0;
				digits_valid <= 1'b1;
			end
		end else if (digits_valid && digits_ready) begin
			digits_valid <= 1'b0;
		end
	end

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	always_ff @(posedge slow_clk) begin
		if (accept) begin
			bin_q           <= sample.value;
			bcd_q           <= '0;
			digits.hex_mode <= sample.hex_mode;
			// top two digits blank in hex
			if (sample.hex_mode)
				digits.digit <= {{(bcd_bits - count_bits){1'b0}}, sample.value};
		end else if (converting) begin
			bin_q <= bin_q << 1;
			bcd_q <= {bcd_adj[bcd_bits-2:0], bin_q[count_bits-1]};
			if (last_step)
				digits.digit <= {bcd_adj[bcd_bits-2:0], bin_q[count_bits-1]};
		end
	end

endmodule

//--- count_source.sv
// input side: tick divider, freezable 24-bit counter and the freeze / hex mode keys
`timescale 1ns/1ns

module count_source #(
	parameter int tick_div     = 3000,
	parameter int stable_ticks = 4
) (
	input  logic                 slow_clk,
	input  logic                 rst,
	input  logic                 key_freeze,
	input  logic                 key_hex,
	output sevenseg_pkg::count_t sample,
	output logic                 sample_valid,
	input  logic                 sample_ready,
	output logic                 tick
);

	import sevenseg_pkg::*;

	localparam int div_bits = (tick_div > 1) ? $clog2(tick_div) : 1;

	logic frozen;
	logic hex_mode;
	logic [div_bits-1:0]   div_cnt;
	logic [count_bits-1:0] value;

	// ----------------------------------------
	// mode keys
	// ----------------------------------------
	key_debounce #(.stable_ticks(stable_ticks)) i_freeze_key (
		.slow_clk (slow_clk),
		.rst      (rst),
		.key      (key_freeze),
		.toggled  (frozen)
	);

	key_debounce #(.stable_ticks(stable_ticks)) i_hex_key (
		.slow_clk (slow_clk),
		.rst      (rst),
		.key      (key_hex),
		.toggled  (hex_mode)
	);

	// ----------------------------------------
	// tick divider and counter
	// ----------------------------------------
	assign tick = (div_cnt == div_bits'(tick_div - 1));

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			div_cnt      <= '0;
			value        <= '0;
			sample_valid <= 1'b0;
		end else begin
			div_cnt      <= tick ? '0 : div_cnt + 1'b1;
			sample_valid <= 1'b1;
			// counting goes on whether or not the consumer is ready
			if (tick && !frozen)
				value <= value + 1'b1;
		end
	end

	// live offer, a stalled consumer picks up the newest value when it accepts
	always_comb begin
		sample.value    = value;
		sample.hex_mode = hex_mode;
		sample.frozen   = frozen;
	end

endmodule

//--- key_debounce.sv
// debounces one active-high key and toggles an output level on every stable press
`timescale 1ns/1ns

module key_debounce #(
	parameter int stable_ticks = 4
) (
	input  logic slow_clk,
	input  logic rst,
	input  logic key,
	output logic toggled
);

	localparam int cnt_bits = $clog2(stable_ticks + 1);

	// two-flop synchroniser
	logic key_meta;
	logic key_sync;
	// last synchronised sample, for change detection
	logic key_prev;
	logic [cnt_bits-1:0] cnt;
	// debounced level
	logic level;

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			key_meta <= 1'b0;
			key_sync <= 1'b0;
			key_prev <= 1'b0;
			cnt      <= '0;
			level    <= 1'b0;
			toggled  <= 1'b0;
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
			key_prev <= key_sync;
			// restart on any change, saturate once stable
			if (key_sync != key_prev)
				cnt <= '0;
			else if (cnt != cnt_bits'(stable_ticks))
				cnt <= cnt + 1'b1;
			// stable long enough, take the new level
			if (cnt == cnt_bits'(stable_ticks) && key_prev != level) begin
				level <= key_prev;
				// only the press flips, the release does not
				if (key_prev)
					toggled <= !toggled;
			end
		end
	end

endmodule

//--- sevenseg_pkg.sv
// shared constants, struct types and segment table for the serial seven-segment driver

package sevenseg_pkg;

	// ----------------------------------------
	// display geometry
	// ----------------------------------------
	localparam int count_bits = 24;
	localparam int num_digits = 8;
	localparam int word_bits  = 16;

	// controller register addresses, digits live at 1..8
	localparam logic [7:0] reg_noop       = 8'h00;
	localparam logic [7:0] reg_decode     = 8'h09;
	localparam logic [7:0] reg_intensity  = 8'h0a;
	localparam logic [7:0] reg_scan_limit = 8'h0b;
	localparam logic [7:0] reg_shutdown   = 8'h0c;
	localparam logic [7:0] reg_test       = 8'h0f;

	// ----------------------------------------
	// payloads between the blocks
	// ----------------------------------------
	typedef struct packed {
		logic [count_bits-1:0] value;
		logic                  hex_mode;
		logic                  frozen;
	} count_t;

	// digit 0 is the rightmost one
	typedef struct packed {
		logic [num_digits-1:0][3:0] digit;
		logic                       hex_mode;
	} digits_t;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} word_t;

	typedef struct packed {
		logic busy;
		logic frozen;
		logic hex_mode;
		logic tick;
	} status_t;

	// segments a..g on bits 6..0, decimal point on bit 7 stays dark
	function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'h7e;
			4'h1: return 8'h30;
			4'h2: return 8'h6d;
			4'h3: return 8'h79;
			4'h4: return 8'h33;
			4'h5: return 8'h5b;
			4'h6: return 8'h5f;
			4'h7: return 8'h70;
			4'h8: return 8'h7f;
			4'h9: return 8'h7b;
			4'ha: return 8'h77;
			4'hb: return 8'h1f;
			4'hc: return 8'h4e;
			4'hd: return 8'h3d;
			4'he: return 8'h4f;
			default: return 8'h47;
		endcase
	endfunction

endpackage
